//--- clk_divider.sv
//------------------------------
// Divider producing clk/1 .. clk/32 with common rising edges
//------------------------------
`timescale 1ns/1ps
`include "clk_sel_defines.svh"

module clk_divider (
  input  logic clk,
  input  logic reset,
  output logic clk_by_1,
  output logic clk_by_2,
  output logic clk_by_4,
  output logic clk_by_8,
  output logic clk_by_16,
  output logic clk_by_32
);

  // One counter bit per divided branch
  localparam int CNT_W = `CLK_SEL_BRANCHES - 1;

  logic [CNT_W-1:0] cnt;
  logic [CNT_W-1:0] div_q;   // Registered divided clocks

  // Inverted bits rise when the lower bits wrap, so all edges line up
  always_ff @(posedge clk) begin
    if (reset) begin
      cnt   <= '0;
      div_q <= '0;             // Branch clocks parked low
    end else begin
      cnt   <= cnt + 1'b1;
      div_q <= ~cnt;
    end
  end

  assign clk_by_1  = clk;      // Straight through
  assign clk_by_2  = div_q[0];
  assign clk_by_4  = div_q[1];
  assign clk_by_8  = div_q[2];
  assign clk_by_16 = div_q[3];
  assign clk_by_32 = div_q[4];

endmodule

//--- clk_sel_ctrl.sv
//------------------------------
// Select request handling and handover tracking in the clk domain
//------------------------------
`timescale 1ns/1ps
`include "clk_sel_defines.svh"

module clk_sel_ctrl (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          sel_wr,
  input  clk_sel_pkg::div_sel_e         sel_div,
  input  logic [`CLK_SEL_BRANCHES-1:0]  active,
  output clk_sel_pkg::div_sel_e         select_req,
  output clk_sel_pkg::div_sel_e         cur_sel,
  output logic                          busy,
  output logic                          sel_done,
  output logic                          sel_err
);

  localparam int SYNC_N = `CLK_SEL_SYNC_STAGES;

  clk_sel_pkg::ctrl_state_e                         state;
  logic [SYNC_N-1:0][`CLK_SEL_BRANCHES-1:0]         active_sync;
  logic                                             sel_valid;
  logic                                             ack_match;
  logic                                             wr_err;
  logic                                             switch_done;

  assign sel_valid = (int'(sel_div) < `CLK_SEL_BRANCHES);
  assign ack_match = (active_sync[SYNC_N-1] == (`CLK_SEL_BRANCHES'(1) << select_req));
  assign wr_err    = sel_wr && ((state != clk_sel_pkg::IDLE) || !sel_valid);
  // A write in the same cycle defers completion, so done and err never overlap
  assign switch_done = (state == clk_sel_pkg::SWITCHING) && ack_match && !sel_wr;
  assign busy        = (state == clk_sel_pkg::SWITCHING);

  always_ff @(posedge clk) begin
    if (reset) begin
      state       <= clk_sel_pkg::IDLE;
      select_req  <= clk_sel_pkg::DIV_1;
      cur_sel     <= clk_sel_pkg::DIV_1;
      active_sync <= '0;
      sel_done    <= 1'b0;
      sel_err     <= 1'b0;
    end else begin
      active_sync <= {active_sync[SYNC_N-2:0], active};  // Into clk
      sel_err     <= wr_err;
      sel_done    <= 1'b0;
      case (state)
        clk_sel_pkg::IDLE: begin
          if (sel_wr && sel_valid) begin
            if (sel_div == cur_sel) begin
              sel_done <= 1'b1;           // Nothing to switch
            end else begin
              select_req <= sel_div;
              state      <= clk_sel_pkg::SWITCHING;
            end
          end
        end
        clk_sel_pkg::SWITCHING: begin
          if (switch_done) begin
            state    <= clk_sel_pkg::IDLE;
            cur_sel  <= select_req;
            sel_done <= 1'b1;
          end
        end
        default: state <= clk_sel_pkg::IDLE;
      endcase
    end
  end

endmodule

//--- clk_sel_defines.svh
//------------------------------
// Shared sizes for the clock selector
// Include wherever a width or depth is needed
//------------------------------
`ifndef CLK_SEL_DEFINES_SVH
`define CLK_SEL_DEFINES_SVH

// Select field width, wide enough for six branch codes
`define CLK_SEL_W 3

// Divided clock branches: clk/1 up to clk/32
`define CLK_SEL_BRANCHES 6

// Flops in every synchronizer chain
`define CLK_SEL_SYNC_STAGES 2

`endif

//--- clk_sel_pkg.sv
//------------------------------
// Types shared by the clock selector blocks
// Referenced by scoped names
//------------------------------
`include "clk_sel_defines.svh"

package clk_sel_pkg;

  // Branch select codes, 6 and 7 are invalid
  typedef enum logic [`CLK_SEL_W-1:0] {
    DIV_1  = 3'd0,
    DIV_2  = 3'd1,
    DIV_4  = 3'd2,
    DIV_8  = 3'd3,
    DIV_16 = 3'd4,
    DIV_32 = 3'd5
  } div_sel_e;

  // Control FSM
  typedef enum logic [1:0] {
    IDLE,
    SWITCHING
  } ctrl_state_e;

endpackage

//--- clk_sel_properties.sv
//------------------------------
// Concurrent checks on branch acknowledges and control strobes
// Bound into clk_selector and clk_sel_ctrl
//------------------------------
`timescale 1ns/1ps
`include "clk_sel_defines.svh"

module clk_sel_properties (
  input logic                          clk,
  input logic                          reset,
  input logic [`CLK_SEL_BRANCHES-1:0]  active,
  input logic                          busy,
  input logic                          sel_done,
  input logic                          sel_err
);

  // Never two gates open at once
  a_active_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(active))
    else $error("more than one branch acknowledge is high");

  a_done_err: assert property (@(posedge clk) disable iff (reset) !(sel_done && sel_err))
    else $error("sel_done and sel_err in the same cycle");

  a_busy_reset: assert property (@(posedge clk) reset |=> !busy)
    else $error("busy is high after reset");

endmodule

// Selector side, strobes tied off
bind clk_selector clk_sel_properties u_sel_props (
  .clk      (clk_by_1),
  .reset    (reset),
  .active   (active),
  .busy     (1'b0),
  .sel_done (1'b0),
  .sel_err  (1'b0)
);

bind clk_sel_ctrl clk_sel_properties u_ctrl_props (
  .clk      (clk),
  .reset    (reset),
  .active   (active),
  .busy     (busy),
  .sel_done (sel_done),
  .sel_err  (sel_err)
);

//--- clk_sel_tb.sv
//------------------------------
// Testbench for the clock selector, driven by clk_sel_tests.txt
// Measures clk_out periods and every phase during a handover
//------------------------------
`timescale 1ns/1ps

module clk_sel_tb;

  localparam int WAIT_LIMIT = 400;   // clk cycles allowed per wait

  logic                  clk;
  logic                  reset;
  logic                  sel_wr;
  clk_sel_pkg::div_sel_e sel_div;
  logic                  clk_out;
  clk_sel_pkg::div_sel_e cur_sel;
  logic                  busy;
  logic                  sel_done;
  logic                  sel_err;

  int          errors = 0;
  bit          aborted = 1'b0;       // Timeout or missing data
  bit          in_handover = 1'b0;
  int          rise_cnt = 0;
  realtime     last_rise = 0.0;
  realtime     prev_rise = 0.0;
  realtime     last_edge = 0.0;
  bit          edge_seen = 1'b0;
  int          model_sel = 0;        // Expected selection code
  logic [31:0] rng = 32'h99ba_683f;

  clk_sel_top dut0 (
    .clk      (clk),
    .reset    (reset),
    .sel_wr   (sel_wr),
    .sel_div  (sel_div),
    .clk_out  (clk_out),
    .cur_sel  (cur_sel),
    .busy     (busy),
    .sel_done (sel_done),
    .sel_err  (sel_err)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Edge log of clk_out, no phase may be shorter than half a clk period
  always @(clk_out) begin
    if (edge_seen && in_handover && ($realtime - last_edge) < 10.0) begin
      $display("[ERROR] %0t: clk_out phase of %0.1f ns in handover", $time, $realtime - last_edge);
      errors++;
    end
    if (clk_out) begin
      prev_rise = last_rise;
      last_rise = $realtime;
      rise_cnt++;
    end
    last_edge = $realtime;
    edge_seen = 1'b1;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  function automatic clk_sel_pkg::div_sel_e code_to_sel(input int code);
    return clk_sel_pkg::div_sel_e'(3'(code));
  endfunction

  //------------------------------
  // Compare tasks
  //------------------------------
  task automatic check_sel(input clk_sel_pkg::div_sel_e got, input clk_sel_pkg::div_sel_e exp);
    if (got !== exp) begin
      $display("[ERROR] %0t: cur_sel is %0d, expected %0d", $time, got, exp);
      errors++;
    end
  endtask

  task automatic check_period(input int got, input int exp);
    if (got != exp) begin
      $display("[ERROR] %0t: clk_out period %0d ns, expected %0d ns", $time, got, exp);
      errors++;
    end
  endtask

  task automatic check_err(input bit got, input bit exp);
    if (got !== exp) begin
      $display("[ERROR] %0t: sel_err seen %0b, expected %0b", $time, got, exp);
      errors++;
    end
  endtask

  //------------------------------
  // Drive and wait
  //------------------------------
  task automatic write_req(input int code);
    @(posedge clk);
    #2;
    sel_wr  = 1'b1;
    sel_div = code_to_sel(code);
    @(posedge clk);
    #2;
    sel_wr = 1'b0;
  endtask

  task automatic wait_strobe(output bit got_done, output bit got_err, output bit busy_seen);
    int n;
    got_done  = 1'b0;
    got_err   = 1'b0;
    busy_seen = 1'b0;
    for (n = 0; n < WAIT_LIMIT && !got_done && !got_err; n++) begin
      @(negedge clk);                // Strobes are stable here
      busy_seen = busy_seen | busy;
      got_done  = sel_done;
      got_err   = sel_err;
    end
    if (!got_done && !got_err) begin
      $display("Timeout: neither sel_done nor sel_err arrived at %0t", $time);
      aborted = 1'b1;
    end
  endtask

  task automatic wait_busy();
    int n;
    bit seen;
    seen = 1'b0;
    for (n = 0; n < WAIT_LIMIT && !seen; n++) begin
      @(negedge clk);
      seen = busy;
    end
    if (!seen) begin
      $display("Timeout: busy never rose after a valid write at %0t", $time);
      aborted = 1'b1;
    end
  endtask

  // Period between the next two rising edges of clk_out
  task automatic measure_period(output int period);
    int start;
    int n;
    start  = rise_cnt;
    period = 0;
    for (n = 0; n < WAIT_LIMIT && rise_cnt < start + 2; n++) begin
      @(negedge clk);
    end
    if (rise_cnt >= start + 2) begin
      period = int'(last_rise - prev_rise);
    end else begin
      $display("Timeout: clk_out stopped toggling at %0t", $time);
      aborted = 1'b1;
    end
  endtask

  task automatic run_test(input logic [127:0] op, input int code, input int exp_period,
                          input bit exp_err);
    bit got_done;
    bit got_err;
    bit busy_seen;
    bit err_seen;
    int period;
    int exp_sel;
    err_seen = 1'b0;
    if (op == "WRITE" || op == "WRITE_BUSY") begin
      in_handover = 1'b1;
      write_req(code);
      if (op == "WRITE_BUSY") begin
        wait_busy();
        if (!aborted) write_req(model_sel);  // Refused while the first is in flight
      end
      if (!aborted) wait_strobe(got_done, got_err, busy_seen);
      err_seen = got_err;
      if (!aborted && op == "WRITE_BUSY" && !got_done) begin
        wait_strobe(got_done, got_err, busy_seen);  // First request finishing
      end
      in_handover = 1'b0;
      // Only a real switch raises busy
      if (op == "WRITE" && busy_seen != (!exp_err && code != model_sel)) begin
        $display("[ERROR] %0t: busy seen %0b on a write of code %0d", $time, busy_seen, code);
        errors++;
      end
      if (!exp_err || op == "WRITE_BUSY") model_sel = code;
    end
    if (aborted) return;
    exp_sel = (op == "CHECK") ? code : model_sel;
    measure_period(period);
    if (aborted) return;
    check_period(period, exp_period);
    if (op != "CHECK") check_err(err_seen, exp_err);
    check_sel(cur_sel, code_to_sel(exp_sel));
  endtask

  initial begin
    int           fd;
    int           cnt;
    int           code;
    int           exp_period;
    int           exp_err;
    int           gap;
    int           tests_run;
    int           errors_before;
    string        line;
    logic [127:0] op;
    reset     = 1'b1;
    sel_wr    = 1'b0;
    sel_div   = clk_sel_pkg::DIV_1;
    tests_run = 0;
    fd = $fopen("clk_sel_tests.txt", "r");
    repeat (2) @(posedge clk);
    #2;
    reset = 1'b0;
    if (fd == 0) begin
      $display("Could not open clk_sel_tests.txt");
      aborted = 1'b1;
    end
    while (!aborted && fd != 0 && $fgets(line, fd) != 0) begin
      cnt = $sscanf(line, "%s %d %d %d", op, code, exp_period, exp_err);
      if (cnt == 4) begin
        rng = xorshift32(rng);
        gap = 1 + int'(rng % 32'd6);   // Idle cycles between tests
        repeat (gap) @(posedge clk);
        errors_before = errors;
        run_test(op, code, exp_period, exp_err != 0);
        tests_run++;
        $display("test %0d %0s %0d: %0s", tests_run, op, code,
                 (errors == errors_before && !aborted) ? "ok" : "FAILED");
      end
    end
    if (fd != 0) $fclose(fd);
    if (tests_run == 0 && !aborted) begin
      $display("No tests were found in clk_sel_tests.txt");
      aborted = 1'b1;
    end
    $display("tests run %0d, errors %0d", tests_run, errors);
    if (errors == 0 && !aborted) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

//--- clk_sel_tests.txt
# op code expected_period_ns expected_err
# WRITE_BUSY issues a second request while busy, the err column is for that one
CHECK 0 20 0
WRITE 1 40 0
WRITE 3 160 0
WRITE 6 160 1
WRITE 5 640 0
WRITE 5 640 0
WRITE 7 640 1
WRITE 0 20 0
WRITE_BUSY 4 320 1
WRITE 2 80 0
WRITE_BUSY 0 20 1
CHECK 0 20 0
WRITE 0 20 0
WRITE 1 40 0
CHECK 1 40 0

//--- clk_sel_top.sv
//------------------------------
// Programmable clock source top level
// Divider, control and glitch-free selector
//------------------------------
`timescale 1ns/1ps
`include "clk_sel_defines.svh"

module clk_sel_top (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   sel_wr,
  input  clk_sel_pkg::div_sel_e  sel_div,
  output logic                   clk_out,
  output clk_sel_pkg::div_sel_e  cur_sel,
  output logic                   busy,
  output logic                   sel_done,
  output logic                   sel_err
);

  logic clk_by_1, clk_by_2, clk_by_4;
  logic clk_by_8, clk_by_16, clk_by_32;

  clk_sel_pkg::div_sel_e         select_req;
  logic [`CLK_SEL_BRANCHES-1:0]  active;

  clk_divider u_divider (
    .clk       (clk),
    .reset     (reset),
    .clk_by_1  (clk_by_1),
    .clk_by_2  (clk_by_2),
    .clk_by_4  (clk_by_4),
    .clk_by_8  (clk_by_8),
    .clk_by_16 (clk_by_16),
    .clk_by_32 (clk_by_32)
  );

  clk_sel_ctrl u_ctrl (
    .clk        (clk),
    .reset      (reset),
    .sel_wr     (sel_wr),
    .sel_div    (sel_div),
    .active     (active),
    .select_req (select_req),
    .cur_sel    (cur_sel),
    .busy       (busy),
    .sel_done   (sel_done),
    .sel_err    (sel_err)
  );

  clk_selector u_selector (
    .clk_by_1   (clk_by_1),
    .clk_by_2   (clk_by_2),
    .clk_by_4   (clk_by_4),
    .clk_by_8   (clk_by_8),
    .clk_by_16  (clk_by_16),
    .clk_by_32  (clk_by_32),
    .reset      (reset),
    .select_req (select_req),
    .clk_out    (clk_out),
    .active     (active)
  );

endmodule

//--- clk_selector.sv
//------------------------------
// Six-way glitch-free clock mux
// Cells are cross-coupled through their acknowledges
//------------------------------
`timescale 1ns/1ps
`include "clk_sel_defines.svh"

module clk_selector (
  input  logic                          clk_by_1,
  input  logic                          clk_by_2,
  input  logic                          clk_by_4,
  input  logic                          clk_by_8,
  input  logic                          clk_by_16,
  input  logic                          clk_by_32,
  input  logic                          reset,
  input  clk_sel_pkg::div_sel_e         select_req,
  output logic                          clk_out,
  output logic [`CLK_SEL_BRANCHES-1:0]  active       // One-hot, per-branch domain
);

  logic [`CLK_SEL_BRANCHES-1:0] ack;     // Bit i is branch code i
  logic [`CLK_SEL_BRANCHES-1:0] gated;

  clk_switch u_by1_switch (
    .clk        (clk_by_1),
    .reset      (reset),
    .alt_ack    (ack[5:1]),
    .select_req (select_req),
    .select_val (clk_sel_pkg::DIV_1),
    .clk_gated  (gated[0]),
    .select_ack (ack[0])
  );

  clk_switch u_by2_switch (
    .clk        (clk_by_2),
    .reset      (reset),
    .alt_ack    ({ack[5:2], ack[0]}),
    .select_req (select_req),
    .select_val (clk_sel_pkg::DIV_2),
    .clk_gated  (gated[1]),
    .select_ack (ack[1])
  );

  clk_switch u_by4_switch (
    .clk        (clk_by_4),
    .reset      (reset),
    .alt_ack    ({ack[5:3], ack[1:0]}),
    .select_req (select_req),
    .select_val (clk_sel_pkg::DIV_4),
    .clk_gated  (gated[2]),
    .select_ack (ack[2])
  );

  clk_switch u_by8_switch (
    .clk        (clk_by_8),
    .reset      (reset),
    .alt_ack    ({ack[5:4], ack[2:0]}),
    .select_req (select_req),
    .select_val (clk_sel_pkg::DIV_8),
    .clk_gated  (gated[3]),
    .select_ack (ack[3])
  );

  clk_switch u_by16_switch (
    .clk        (clk_by_16),
    .reset      (reset),
    .alt_ack    ({ack[5], ack[3:0]}),
    .select_req (select_req),
    .select_val (clk_sel_pkg::DIV_16),
    .clk_gated  (gated[4]),
    .select_ack (ack[4])
  );

  clk_switch u_by32_switch (
    .clk        (clk_by_32),
    .reset      (reset),
    .alt_ack    (ack[4:0]),
    .select_req (select_req),
    .select_val (clk_sel_pkg::DIV_32),
    .clk_gated  (gated[5]),
    .select_ack (ack[5])
  );

  // At most one gate open, so a plain OR
  assign clk_out = |gated;
  assign active  = ack;

endmodule

//--- clk_switch.sv
//------------------------------
// Glitch-free gate cell for one clock branch
// Opens only once every other branch reports closed
//------------------------------
`timescale 1ns/1ps
`include "clk_sel_defines.svh"

module clk_switch (
  input  logic                          clk,         // Branch clock
  input  logic                          reset,
  input  logic [`CLK_SEL_BRANCHES-2:0]  alt_ack,     // Other branches' acks
  input  clk_sel_pkg::div_sel_e         select_req,
  input  clk_sel_pkg::div_sel_e         select_val,  // Identity code of this cell
  output logic                          clk_gated,
  output logic                          select_ack
);

  localparam int SYNC_N = `CLK_SEL_SYNC_STAGES;

  logic              sel_match;
  logic              en_req;
  logic [SYNC_N-1:0] en_sync;

  assign sel_match = (select_req == select_val);

  // Wait until all other gates are closed
  assign en_req = sel_match && !(|alt_ack);

  //------------------------------
  // Falling-edge enable chain
  //------------------------------
  // Updating on the falling edge keeps every gate change in the low phase.
  // Losing the select clears the whole chain at once, so the gate closes
  // on the next falling edge.
  always_ff @(negedge clk) begin
    if (reset || !sel_match) begin
      en_sync <= '0;
    end else begin
      en_sync <= {en_sync[SYNC_N-2:0], en_req};
    end
  end

  assign select_ack = en_sync[SYNC_N-1];

  // Enable only moves while clk is low
  assign clk_gated = clk & select_ack;

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build the clock selector testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module clk_sel_tb -f src.f -o clk_sel_sim

./obj_dir/clk_sel_sim 2>&1 | tee sim.log

if grep -qx "sim passed" sim.log; then
  echo "Simulation PASS"
  exit 0
fi
echo "Simulation FAIL"
exit 1

//--- src.f
+incdir+.
clk_sel_pkg.sv
clk_divider.sv
clk_switch.sv
clk_selector.sv
clk_sel_ctrl.sv
clk_sel_top.sv
clk_sel_properties.sv
clk_sel_tb.sv
